// ==== am_codes_pkg.sv ====
package am_codes_pkg;

	localparam int NB_AM      = 48;	// compared marker field
	localparam int N_ALIGNER  = 20;	// one marker per pcs lane
	localparam int NB_LANE_ID = 5;

	typedef logic [NB_AM-1:0]      am_word_t;
	typedef logic [N_ALIGNER-1:0]  am_vec_t;	// one bit per marker
	typedef logic [NB_LANE_ID-1:0] lane_id_t;

	// entry k holds the codeword of pcs lane k
	localparam am_word_t AM_TABLE [0:N_ALIGNER-1] = '{
		48'hC168213E97DE,	// lane 0
		48'h9D718E628E71,
		48'h594BE8A6B417,
		48'h4D957BB26A84,
		48'hF507090AF8F6,
		48'hDD14C222EB3D,	// lane 5
		48'h9A4A2665B5D9,
		48'h7B456684BA99,
		48'hA024765FDB89,
		48'h68C9FB973604,
		48'hFD6C99029366,	// lane 10
		48'hB99155466EAA,
		48'h5CB9B2A3464D,
		48'h1AF8BDE50742,
		48'h83C7CA7C3835,
		48'h3536CDCAC932,	// lane 15
		48'hC4314C3BCEB3,
		48'hADD6B7522948,
		48'h5F662AA099D5,
		48'hC0F0E53F0F1A	// lane 19
	};

endpackage

// ==== am_lock_ctrl_pkg.sv ====
package am_lock_ctrl_pkg;

	typedef enum logic [1:0]
	{
		ST_SEARCH,	// compare against every marker
		ST_CONFIRM,	// first hit seen, waiting for the second
		ST_LOCKED,
		ST_SLIP		// locked but at least one bad marker
	} lock_state_t;

	localparam int GOOD_TO_LOCK  = 2;	// consecutive good markers for lock
	localparam int BAD_TO_UNLOCK = 4;	// consecutive bad markers to drop lock

	// wide enough for the larger of the two thresholds
	localparam int NB_LOCK_CNT =
		$clog2(((GOOD_TO_LOCK > BAD_TO_UNLOCK) ? GOOD_TO_LOCK : BAD_TO_UNLOCK) + 1);

	typedef logic [NB_LOCK_CNT-1:0] lock_cnt_t;

	localparam int AM_PERIOD_DEFAULT = 16384;	// valid blocks between markers
	localparam int NB_PERIOD         = 15;

	typedef logic [NB_PERIOD-1:0] period_t;

endpackage

// ==== am_lock_comparator.sv ====
`timescale 1ns/1ps

module am_lock_comparator
(
	input  logic                   i_enable_mask,	// search in progress
	input  logic                   i_timer_done,	// marker due on this block
	input  am_codes_pkg::am_word_t i_am_value,
	input  am_codes_pkg::am_word_t i_compare_mask,	// 1 = bit takes part
	input  am_codes_pkg::am_vec_t  i_match_mask,	// markers allowed to hit
	output logic                   o_am_match,
	output am_codes_pkg::am_vec_t  o_match_vector
);
	import am_codes_pkg::*;

	am_vec_t lane_hit;
	am_vec_t match_vector;
	logic    any_hit;
	logic    window;

	// one masked compare per marker codeword
	for (genvar k = 0; k < N_ALIGNER; k++)
	begin : g_lane
		am_word_t agree;

		// ignored bits are forced to agree
		assign agree       = ~(i_am_value ^ AM_TABLE[k]) | ~i_compare_mask;
		assign lane_hit[k] = &agree;
	end

	assign match_vector = lane_hit & i_match_mask;	// only expected markers
	assign any_hit      = |match_vector;

	// a hit counts while searching or where the next marker is due
	assign window = i_enable_mask | i_timer_done;

	assign o_am_match     = any_hit & window;
	assign o_match_vector = match_vector;

endmodule

// ==== am_lock_timer.sv ====
`timescale 1ns/1ps

module am_lock_timer
#(
	parameter int P_AM_PERIOD = am_lock_ctrl_pkg::AM_PERIOD_DEFAULT
)
(
	input  logic i_clock,
	input  logic i_rst_n,
	input  logic i_valid,
	input  logic i_restart,	// marker found on this block
	output logic o_timer_done
);
	import am_lock_ctrl_pkg::*;

	period_t count;		// valid blocks left until the next marker
	period_t load_value;
	logic    last_block;
	logic    reload;

	// restart block counts as block zero
	assign load_value = period_t'(P_AM_PERIOD - 1);

	assign last_block   = (count == '0);
	assign o_timer_done = i_valid && last_block;

	// the done block also starts the next period
	assign reload = i_valid && (i_restart || last_block);

	// free-runs after reset until the first hit restarts it
	always_ff @(posedge i_clock)
	begin
		if (!i_rst_n)
			count <= load_value;
		else if (reload)
			count <= load_value;
		else if (i_valid)
			count <= count - 1'b1;	// idle cycles hold the count
	end

endmodule

// ==== am_lock_fsm.sv ====
`timescale 1ns/1ps

module am_lock_fsm
(
	input  logic                   i_clock,
	input  logic                   i_rst_n,
	input  logic                   i_valid,
	input  logic                   i_am_match,
	input  am_codes_pkg::am_vec_t  i_match_vector,
	input  logic                   i_timer_done,
	output logic                   o_enable_mask,	// open compare window
	output am_codes_pkg::am_vec_t  o_match_mask,	// markers the comparator accepts
	output logic                   o_timer_restart,
	output logic                   o_lock,
	output am_codes_pkg::lane_id_t o_lane_id,
	output logic                   o_am_found
);
	import am_codes_pkg::*;
	import am_lock_ctrl_pkg::*;

	lock_state_t state;
	lock_state_t state_next;
	lock_cnt_t   good_cnt;
	lock_cnt_t   good_cnt_next;
	lock_cnt_t   bad_cnt;
	lock_cnt_t   bad_cnt_next;
	am_vec_t     expected_mask;
	am_vec_t     expected_mask_next;
	lane_id_t    lane_id;
	lane_id_t    lane_id_next;
	lane_id_t    hit_lane;
	logic        lock;
	logic        lock_next;
	logic        am_found;
	logic        am_found_next;
	logic        first_hit;
	logic        judge;

	// lowest set bit wins if several markers hit
	function automatic lane_id_t lowest_lane(input am_vec_t vec);
		lane_id_t id;

		id = '0;
		for (int k = N_ALIGNER - 1; k >= 0; k--)
		begin
			if (vec[k])
				id = lane_id_t'(k);
		end
		return id;
	endfunction

	assign hit_lane  = lowest_lane(i_match_vector);
	assign first_hit = i_valid && (state == ST_SEARCH) && i_am_match;
	assign judge     = i_valid && i_timer_done;	// block where a marker is due

	always_comb
	begin
		state_next         = state;
		good_cnt_next      = good_cnt;
		bad_cnt_next       = bad_cnt;
		expected_mask_next = expected_mask;
		lane_id_next       = lane_id;
		lock_next          = lock;
		am_found_next      = 1'b0;

		case (state)
			ST_SEARCH:
			begin
				if (first_hit)
				begin
					lane_id_next       = hit_lane;
					expected_mask_next = am_vec_t'(1) << hit_lane;
					good_cnt_next      = lock_cnt_t'(1);	// first hit counts as good
					state_next         = ST_CONFIRM;
				end
			end

			ST_CONFIRM:
			begin
				if (judge)
				begin
					if (i_am_match)
					begin
						good_cnt_next = good_cnt + 1'b1;
						if (good_cnt_next == lock_cnt_t'(GOOD_TO_LOCK))
						begin
							lock_next    = 1'b1;
							bad_cnt_next = '0;
							state_next   = ST_LOCKED;
						end
					end
					else
					begin
						good_cnt_next = '0;	// wrong or missing marker
						state_next    = ST_SEARCH;
					end
				end
			end

			ST_LOCKED,
			ST_SLIP:
			begin
				if (judge)
				begin
					if (i_am_match)
					begin
						am_found_next = 1'b1;
						bad_cnt_next  = '0;
						state_next    = ST_LOCKED;
					end
					else
					begin
						bad_cnt_next = bad_cnt + 1'b1;
						if (bad_cnt_next == lock_cnt_t'(BAD_TO_UNLOCK))
						begin
							lock_next     = 1'b0;
							bad_cnt_next  = '0;
							good_cnt_next = '0;
							state_next    = ST_SEARCH;	// restart the search
						end
						else
							state_next = ST_SLIP;
					end
				end
			end

			default:
				state_next = ST_SEARCH;
		endcase
	end

	always_ff @(posedge i_clock)
	begin
		if (!i_rst_n)
		begin
			state         <= ST_SEARCH;
			good_cnt      <= '0;
			bad_cnt       <= '0;
			expected_mask <= '0;
			lane_id       <= '0;
			lock          <= 1'b0;
			am_found      <= 1'b0;
		end
		else
		begin
			state         <= state_next;
			good_cnt      <= good_cnt_next;
			bad_cnt       <= bad_cnt_next;
			expected_mask <= expected_mask_next;
			lane_id       <= lane_id_next;
			lock          <= lock_next;
			am_found      <= am_found_next;
		end
	end

	assign o_enable_mask   = (state == ST_SEARCH);
	assign o_match_mask    = (state == ST_SEARCH) ? '1 : expected_mask;
	assign o_timer_restart = first_hit;	// align timer to the hit
	assign o_lock          = lock;
	assign o_lane_id       = lane_id;
	assign o_am_found      = am_found;

endmodule

// ==== am_lock_lane.sv ====
`timescale 1ns/1ps

module am_lock_lane
#(
	parameter int P_AM_PERIOD = am_lock_ctrl_pkg::AM_PERIOD_DEFAULT
)
(
	input  logic                   i_clock,
	input  logic                   i_rst_n,
	input  logic                   i_valid,	// one block per valid cycle
	input  am_codes_pkg::am_word_t i_payload,	// descrambled block payload
	input  am_codes_pkg::am_word_t i_compare_mask,
	output logic                   o_lock,
	output am_codes_pkg::lane_id_t o_lane_id,
	output logic                   o_am_found
);
	import am_codes_pkg::*;

	logic    enable_mask;	// fsm -> comparator
	am_vec_t match_mask;
	logic    am_match;	// comparator -> fsm
	am_vec_t match_vector;
	logic    timer_restart;	// fsm -> timer
	logic    timer_done;	// timer -> comparator and fsm

	am_lock_comparator u_comparator
	(
		.i_enable_mask  (enable_mask),
		.i_timer_done   (timer_done),
		.i_am_value     (i_payload),
		.i_compare_mask (i_compare_mask),
		.i_match_mask   (match_mask),
		.o_am_match     (am_match),
		.o_match_vector (match_vector)
	);

	am_lock_timer
	#(
		.P_AM_PERIOD (P_AM_PERIOD)
	)
	u_timer
	(
		.i_clock      (i_clock),
		.i_rst_n      (i_rst_n),
		.i_valid      (i_valid),
		.i_restart    (timer_restart),
		.o_timer_done (timer_done)
	);

	am_lock_fsm u_fsm
	(
		.i_clock         (i_clock),
		.i_rst_n         (i_rst_n),
		.i_valid         (i_valid),
		.i_am_match      (am_match),
		.i_match_vector  (match_vector),
		.i_timer_done    (timer_done),
		.o_enable_mask   (enable_mask),
		.o_match_mask    (match_mask),
		.o_timer_restart (timer_restart),
		.o_lock          (o_lock),
		.o_lane_id       (o_lane_id),
		.o_am_found      (o_am_found)
	);

endmodule

// ==== am_lock_tb.sv ====
`timescale 1ns/1ps

module am_lock_tb;
	import am_codes_pkg::*;

	localparam int       AM_P         = 16;	// short marker period
	localparam am_word_t FULL_MASK    = '1;
	localparam am_word_t PART_MASK    = 48'hFFFF_FFFF_FF00;	// low byte ignored
	localparam am_word_t MASKED_FLIPS = 48'h0000_0000_005A;	// inside the ignored byte
	localparam am_word_t BAD_FLIPS    = 48'h0000_0100_0000;

	logic     i_clock;
	logic     i_rst_n;
	logic     i_valid;
	am_word_t i_payload;
	am_word_t i_compare_mask;
	logic     o_lock;
	lane_id_t o_lane_id;
	logic     o_am_found;

	integer   seed;
	am_word_t cmp_mask;
	logic     idle_mode;	// random invalid cycles between blocks
	logic     exp_lock;
	logic     exp_found;
	lane_id_t exp_lane;
	logic     pend_lock;	// expectation for the block just driven
	logic     pend_found;
	int       errors;
	int       errors_at_start;
	int       tests_run;
	int       tests_failed;

	am_lock_lane
	#(
		.P_AM_PERIOD (AM_P)
	)
	u_am_lock_lane
	(
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_valid        (i_valid),
		.i_payload      (i_payload),
		.i_compare_mask (i_compare_mask),
		.o_lock         (o_lock),
		.o_lane_id      (o_lane_id),
		.o_am_found     (o_am_found)
	);

	initial
	begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	a_lock: assert property (@(posedge i_clock) disable iff (!i_rst_n) o_lock == exp_lock)
	else
	begin
		errors = errors + 1;
		$display("mismatch at %0t: o_lock is %b, expected %b", $time, $sampled(o_lock),
			$sampled(exp_lock));
	end

	a_found: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_am_found == exp_found)
	else
	begin
		errors = errors + 1;
		$display("mismatch at %0t: o_am_found is %b, expected %b", $time, $sampled(o_am_found),
			$sampled(exp_found));
	end

	a_lane: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		exp_lock |-> o_lane_id == exp_lane)
	else
	begin
		errors = errors + 1;
		$display("mismatch at %0t: o_lane_id is %0d, expected %0d", $time, $sampled(o_lane_id),
			$sampled(exp_lane));
	end

	a_found_locked: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_am_found |-> o_lock)
	else
	begin
		errors = errors + 1;
		$display("mismatch at %0t: o_am_found pulsed while o_lock is low", $time);
	end

	// random payload that hits no marker under the current mask
	function automatic am_word_t draw_filler();
		am_word_t word;
		logic     clash;

		do
		begin
			word[31:0]  = $random(seed);
			word[47:32] = 16'($random(seed));
			clash       = 1'b0;
			for (int k = 0; k < N_ALIGNER; k++)
			begin
				if (((word ^ AM_TABLE[k]) & cmp_mask) == '0)
					clash = 1'b1;
			end
		end
		while (clash);
		return word;
	endfunction

	// outputs for a block show up one edge after the dut samples it
	task automatic send_block(input logic valid, input am_word_t payload,
		input logic lock_after, input logic found_after);
		@(posedge i_clock);
		exp_lock       <= pend_lock;
		exp_found      <= pend_found;
		i_valid        <= valid;
		i_payload      <= payload;
		i_compare_mask <= cmp_mask;
		pend_lock  = lock_after;
		pend_found = found_after;
	endtask

	task automatic maybe_idle();
		int n;

		if (idle_mode && (($random(seed) & 3) == 0))
		begin
			n = ($random(seed) & 1) + 1;
			repeat (n) send_block(1'b0, AM_TABLE[0], pend_lock, 1'b0);	// marker on idle cycle
		end
	endtask

	task automatic send_fillers(input int n);
		for (int i = 0; i < n; i++)
		begin
			maybe_idle();
			send_block(1'b1, draw_filler(), pend_lock, 1'b0);
		end
	endtask

	// marker block followed by the rest of one period
	task automatic send_period(input am_word_t payload, input logic lock_after,
		input logic found_after);
		maybe_idle();
		send_block(1'b1, payload, lock_after, found_after);
		send_fillers(AM_P - 1);
	endtask

	task automatic apply_reset();
		@(posedge i_clock);
		i_rst_n        <= 1'b0;
		i_valid        <= 1'b0;
		i_payload      <= '0;
		i_compare_mask <= cmp_mask;
		exp_lock       <= 1'b0;
		exp_found      <= 1'b0;
		pend_lock  = 1'b0;
		pend_found = 1'b0;
		repeat (5) @(posedge i_clock);
		i_rst_n <= 1'b1;
	endtask

	task automatic wait_lock(input logic level, input int limit);
		int   n;
		logic seen;

		n    = 0;
		seen = 1'b0;
		while (!seen && n < limit)
		begin
			send_block(1'b0, draw_filler(), pend_lock, 1'b0);
			seen = (o_lock === level);
			n    = n + 1;
		end
		if (!seen)
		begin
			errors = errors + 1;
			$display("timeout: o_lock did not settle at %b within %0d cycles", level, limit);
		end
	endtask

	task automatic end_test(input string name);
		tests_run = tests_run + 1;
		if (errors == errors_at_start)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed = tests_failed + 1;
			$display("test %0d %s: failed with %0d errors", tests_run, name,
				errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	initial
	begin
		seed            = 32'h49b9;
		i_rst_n         = 1'b0;
		i_valid         = 1'b0;
		i_payload       = '0;
		i_compare_mask  = FULL_MASK;
		cmp_mask        = FULL_MASK;
		idle_mode       = 1'b0;
		exp_lock        = 1'b0;
		exp_found       = 1'b0;
		exp_lane        = '0;
		pend_lock       = 1'b0;
		pend_found      = 1'b0;
		errors          = 0;
		errors_at_start = 0;
		tests_run       = 0;
		tests_failed    = 0;

		apply_reset();
		exp_lane = 5'd7;
		send_fillers(5);
		send_period(AM_TABLE[7], 1'b0, 1'b0);	// first hit, confirm
		send_period(AM_TABLE[7], 1'b1, 1'b0);	// second marker locks
		send_period(AM_TABLE[7], 1'b1, 1'b1);
		wait_lock(1'b1, 4);
		end_test("lock on lane 7");

		// still locked from the previous test
		repeat (3) send_period(AM_TABLE[7] ^ BAD_FLIPS, 1'b1, 1'b0);
		send_period(AM_TABLE[7], 1'b1, 1'b1);	// clears the bad count
		repeat (3) send_period(AM_TABLE[7] ^ BAD_FLIPS, 1'b1, 1'b0);
		send_period(AM_TABLE[7] ^ BAD_FLIPS, 1'b0, 1'b0);
		wait_lock(1'b0, 4);
		end_test("lose lock after four bad markers");

		apply_reset();
		exp_lane = 5'd5;
		send_fillers(3);
		send_period(AM_TABLE[3], 1'b0, 1'b0);
		send_period(AM_TABLE[5], 1'b0, 1'b0);	// wrong lane where lane 3 is due
		send_fillers(7);
		send_period(AM_TABLE[5], 1'b0, 1'b0);	// new search hit
		send_period(AM_TABLE[5], 1'b1, 1'b0);
		send_period(AM_TABLE[5], 1'b1, 1'b1);
		wait_lock(1'b1, 4);
		end_test("confirm miss returns to search");

		cmp_mask = PART_MASK;
		apply_reset();
		exp_lane = 5'd12;
		send_fillers(4);
		send_period(AM_TABLE[12] ^ MASKED_FLIPS, 1'b0, 1'b0);
		send_period(AM_TABLE[12] ^ MASKED_FLIPS, 1'b1, 1'b0);
		send_period(AM_TABLE[12] ^ MASKED_FLIPS, 1'b1, 1'b1);
		wait_lock(1'b1, 4);
		cmp_mask = FULL_MASK;
		apply_reset();
		send_fillers(4);
		repeat (3) send_period(AM_TABLE[12] ^ MASKED_FLIPS, 1'b0, 1'b0);
		wait_lock(1'b0, 4);
		end_test("compare mask");

		apply_reset();
		idle_mode = 1'b1;
		exp_lane  = 5'd7;
		send_fillers(5);
		send_period(AM_TABLE[7], 1'b0, 1'b0);
		send_period(AM_TABLE[7], 1'b1, 1'b0);
		send_period(AM_TABLE[7], 1'b1, 1'b1);
		send_period(AM_TABLE[7], 1'b1, 1'b1);
		idle_mode = 1'b0;
		wait_lock(1'b1, 4);
		end_test("invalid cycles");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== am_lock.f ====
am_codes_pkg.sv
am_lock_ctrl_pkg.sv
am_lock_comparator.sv
am_lock_timer.sv
am_lock_fsm.sv
am_lock_lane.sv
am_lock_tb.sv
